// ==== ladder.f ====
hw/ladder_pkg.sv
hw/ladder_regfile.sv
hw/field_alu.sv
hw/ladder_sequencer.sv
hw/ladder_top.sv
sim/ladder_checker.sv
sim/ladder_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the ladder engine testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -j 0 --top-module ladder_tb \
        -f ladder.f -o ladder_sim \
    && ./obj_dir/ladder_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run.sh: pass" \
    || { echo "run.sh: fail"; exit 1; }

// ==== sim/ladder_tb.sv ====
`timescale 1ns/1ps
// Ladder engine testbench
// builds a table of scalars and base coordinates with reference
// results, sends each request through the engine and takes the
// response under a per-entry back-pressure hold
module ladder_tb;

    localparam int          WID            = 16;
    localparam int unsigned MODULUS        = 65521;
    localparam int unsigned A24            = 121665 % MODULUS;
    localparam int          NUM_FIXED      = 8;
    localparam int          NUM_TESTS      = NUM_FIXED + 8;
    localparam int          ACCEPT_TIMEOUT = 100;
    localparam int          RESULT_TIMEOUT = 20000;   // cycles per ladder result

    typedef struct packed {
        logic [WID-1:0] x;
        logic [WID-1:0] z;
    } point_t;

    typedef struct packed {
        logic [WID-1:0] scalar;
        logic [WID-1:0] u;
        logic [7:0]     hold;     // cycles out_ready stays low
        point_t         exp_pt;
    } vector_t;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic [2*WID-1:0] in_data;
    logic             in_ready;
    logic             out_ready;
    logic             out_valid;
    logic [WID-1:0]   out_x;
    logic [WID-1:0]   out_z;

    string            test_name [NUM_TESTS];
    vector_t          vec       [NUM_TESTS];
    int               timeout_count = 0;
    logic             timed_out     = 1'b0;

    ladder_top #(.WID(WID), .MODULUS(MODULUS), .A24(A24)) i_dut (
        .clk, .rst, .in_valid, .in_data, .in_ready,
        .out_ready, .out_valid, .out_x, .out_z
    );

    ladder_checker #(.WID(WID), .MAX_TESTS(NUM_TESTS)) i_check (
        .clk, .rst, .in_valid, .in_ready, .out_valid, .out_ready, .out_x, .out_z
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // x-only ladder reference mod MODULUS
    function automatic logic [WID-1:0] mod_add(input logic [WID-1:0] a, input logic [WID-1:0] b);
        return WID'((longint'(a) + longint'(b)) % longint'(MODULUS));
    endfunction

    function automatic logic [WID-1:0] mod_sub(input logic [WID-1:0] a, input logic [WID-1:0] b);
        return WID'((longint'(a) + longint'(MODULUS) - longint'(b)) % longint'(MODULUS));
    endfunction

    function automatic logic [WID-1:0] mod_mul(input logic [WID-1:0] a, input logic [WID-1:0] b);
        return WID'((longint'(a) * longint'(b)) % longint'(MODULUS));
    endfunction

    function automatic point_t ladder_ref(input logic [WID-1:0] k, input logic [WID-1:0] u);
        logic [WID-1:0] x2, z2, x3, z3, a, aa, b, bb, e, t0, c, d, da, cb, tmp;
        logic           swap;
        x2   = WID'(1);
        z2   = '0;
        x3   = u;
        z3   = WID'(1);
        swap = 1'b0;
        for (int t = WID - 1; t >= 0; t--)
        begin
            if (swap ^ k[t])
            begin
                tmp = x2;
                x2  = x3;
                x3  = tmp;
                tmp = z2;
                z2  = z3;
                z3  = tmp;
            end
            swap = k[t];
            a    = mod_add(x2, z2);
            aa   = mod_mul(a, a);
            b    = mod_sub(x2, z2);
            bb   = mod_mul(b, b);
            e    = mod_sub(aa, bb);
            x2   = mod_mul(aa, bb);
            t0   = mod_add(aa, mod_mul(WID'(A24), e));
            z2   = mod_mul(e, t0);
            c    = mod_add(x3, z3);
            d    = mod_sub(x3, z3);
            da   = mod_mul(d, a);
            cb   = mod_mul(c, b);
            x3   = mod_mul(mod_add(da, cb), mod_add(da, cb));
            t0   = mod_mul(mod_sub(da, cb), mod_sub(da, cb));
            z3   = mod_mul(u, t0);      // x1 is the base
        end
        if (swap)
        begin
            x2 = x3;
            z2 = z3;
        end
        return '{x: x2, z: z2};
    endfunction

    task automatic add_vector(input int idx, input string name, input logic [WID-1:0] k,
                              input logic [WID-1:0] u, input logic [7:0] hold);
        test_name[idx] = name;
        vec[idx]       = '{scalar: k, u: u, hold: hold, exp_pt: ladder_ref(k, u)};
        i_check.expect_result(idx, name, vec[idx].exp_pt.x, vec[idx].exp_pt.z);
    endtask

    task automatic build_table();
        add_vector(0, "scalar_zero", '0, WID'(9), 8'd0);
        add_vector(1, "scalar_one", WID'(1), WID'(9), 8'd0);
        add_vector(2, "scalar_two", WID'(2), WID'(9), 8'd1);
        add_vector(3, "scalar_msb", 16'h8000, WID'(1234), 8'd0);
        add_vector(4, "scalar_ones", 16'hffff, WID'(9), 8'd2);
        add_vector(5, "scalar_mixed", 16'ha5c3, WID'(40000), 8'd0);
        add_vector(6, "base_zero", 16'h1357, '0, 8'd0);
        add_vector(7, "base_max", 16'h2468, WID'(MODULUS - 1), 8'd3);
        for (int i = NUM_FIXED; i < NUM_TESTS; i++)
            add_vector(i, $sformatf("random_%0d", i - NUM_FIXED), WID'($urandom()),
                       WID'($urandom() % MODULUS), 8'($urandom_range(20, 5)));
    endtask

    task automatic report_timeout(input int idx, input string what);
        timeout_count++;
        timed_out = 1'b1;
        $display("timeout in %s: %s", test_name[idx], what);
    endtask

    //////////////////////////////////////////////////
    // one request and its response
    task automatic run_vector(input int idx);
        int waited;
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= {vec[idx].scalar, vec[idx].u};
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!in_ready && waited < ACCEPT_TIMEOUT);
        if (!in_ready)
        begin
            report_timeout(idx, "request never accepted");
            return;
        end
        @(posedge clk);             // accepted on this edge
        in_data <= ~in_data;        // keep offering a request while busy
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!out_valid && waited < RESULT_TIMEOUT);
        if (!out_valid)
        begin
            report_timeout(idx, "no result from the engine");
            return;
        end
        repeat (vec[idx].hold) @(posedge clk);
        @(posedge clk);
        out_ready <= 1'b1;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!(out_valid && out_ready) && waited < ACCEPT_TIMEOUT);
        if (!(out_valid && out_ready))
        begin
            report_timeout(idx, "result not held until taken");
            return;
        end
        @(posedge clk);
        out_ready <= 1'b0;
        in_valid  <= 1'b0;
    endtask

    initial
    begin
        int unsigned seed_ret;
        int          total;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        seed_ret  = $urandom(85);
        build_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < NUM_TESTS && !timed_out; i++)
            run_vector(i);
        repeat (2) @(posedge clk);
        total = i_check.mismatch_count + i_check.protocol_count + timeout_count;
        $display("errors: %0d mismatch, %0d protocol, %0d timeout, %0d of %0d results",
                 i_check.mismatch_count, i_check.protocol_count, timeout_count,
                 i_check.result_count, NUM_TESTS);
        if (total == 0 && i_check.result_count == NUM_TESTS)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== sim/ladder_checker.sv ====
`timescale 1ns/1ps
// Ladder engine checker
// watches the request and response ports of the engine, compares
// each returned (x, z) pair with the expected one and checks the
// valid/ready rules on both sides
module ladder_checker #(
    parameter int WID       = 16,
    parameter int MAX_TESTS = 32
)
(
    input logic           clk,
    input logic           rst,
    input logic           in_valid,
    input logic           in_ready,
    input logic           out_valid,
    input logic           out_ready,
    input logic [WID-1:0] out_x,
    input logic [WID-1:0] out_z
);

    string          name_tab [MAX_TESTS];
    logic [WID-1:0] exp_x    [MAX_TESTS];
    logic [WID-1:0] exp_z    [MAX_TESTS];

    int             mismatch_count = 0;
    int             protocol_count = 0;
    int             result_count   = 0;
    logic           reset_checked  = 1'b0;
    logic           busy;               // accepted, response not yet taken
    logic           held;               // result offered but not taken
    logic [WID-1:0] held_x;
    logic [WID-1:0] held_z;

    task automatic expect_result(input int idx, input string name,
                                 input logic [WID-1:0] x, input logic [WID-1:0] z);
        name_tab[idx] = name;
        exp_x[idx]    = x;
        exp_z[idx]    = z;
    endtask

    task automatic protocol_error(input string what);
        protocol_count++;
        $display("protocol error at %0t: %s", $time, what);
    endtask

    task automatic compare_result();
        if (result_count >= MAX_TESTS)
            protocol_error("result returned with no request left in the table");
        else
        begin
            if (out_x !== exp_x[result_count])
            begin
                mismatch_count++;
                $display("mismatch %s x expected %h actual %h",
                         name_tab[result_count], exp_x[result_count], out_x);
            end
            if (out_z !== exp_z[result_count])
            begin
                mismatch_count++;
                $display("mismatch %s z expected %h actual %h",
                         name_tab[result_count], exp_z[result_count], out_z);
            end
        end
        result_count++;
    endtask

    //////////////////////////////////////////////////
    // sampled mid-cycle, a handshake seen here completes on the next rising edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            busy = 1'b0;
            held = 1'b0;
        end
        else
        begin
            if (!reset_checked && (!in_ready || out_valid))
                protocol_error("engine not idle after reset");
            reset_checked = 1'b1;
            if (held && !out_valid)
                protocol_error("out_valid dropped before the result was taken");
            else if (held && (out_x !== held_x || out_z !== held_z))
                protocol_error("result changed while out_ready was low");
            if (busy && in_ready)
                protocol_error("in_ready high while a request is in flight");
            if (out_valid && !busy)
                protocol_error("out_valid high with no request accepted");
            if (in_valid && in_ready)
            begin
                if (busy)
                    protocol_error("second request accepted while busy");
                busy = 1'b1;
            end
            if (out_valid && out_ready)
            begin
                compare_result();
                busy = 1'b0;
            end
            held   = out_valid && !out_ready;
            held_x = out_x;
            held_z = out_z;
        end
    end

endmodule

// ==== hw/ladder_top.sv ====
`timescale 1ns/1ps
// Montgomery ladder engine, top level
// x-only scalar multiplication over a small prime field, returns
// the projective pair (x2, z2) for a scalar and a base coordinate
module ladder_top
    import ladder_pkg::*;
#(
    parameter int          WID     = 16,
    parameter int unsigned MODULUS = 65521,
    parameter int unsigned A24     = 121665 % MODULUS
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [2*WID-1:0] in_data,   // scalar in the upper half
    output logic             in_ready,
    input  logic             out_ready,
    output logic             out_valid,
    output logic [WID-1:0]   out_x,
    output logic [WID-1:0]   out_z
);

    typedef struct packed {
        logic [WID-1:0] scalar;
        logic [WID-1:0] base_u;
    } ladder_req_t;

    ladder_req_t    req;
    // sequencer to ALU
    logic           alu_valid;
    logic           alu_ready;
    alu_op_e        alu_op;
    logic [WID-1:0] alu_a;
    logic [WID-1:0] alu_b;
    logic           alu_swap;
    logic           resp_valid;
    logic [WID-1:0] resp_y0;
    logic [WID-1:0] resp_y1;
    // sequencer to register file
    reg_addr_e      ra_addr;
    reg_addr_e      rb_addr;
    reg_addr_e      wa;
    logic           we;
    logic [WID-1:0] wd;
    logic [WID-1:0] ra_data;
    logic [WID-1:0] rb_data;

    assign req = ladder_req_t'(in_data);

    ladder_sequencer #(.WID(WID), .A24(A24)) i_seq (
        .clk, .rst, .in_valid,
        .in_scalar(req.scalar), .in_base(req.base_u), .in_ready,
        .out_ready, .out_valid, .out_x, .out_z,
        .alu_valid, .alu_op, .alu_a, .alu_b, .alu_swap,
        .alu_ready, .resp_valid, .resp_y0, .resp_y1,
        .ra_addr, .rb_addr, .we, .wa, .wd, .ra_data, .rb_data
    );

    ladder_regfile #(.WID(WID)) i_regfile (
        .clk, .rst, .ra_addr, .rb_addr, .we, .wa, .wd, .ra_data, .rb_data
    );

    field_alu #(.WID(WID), .MODULUS(MODULUS)) i_alu (
        .clk, .rst, .alu_valid, .alu_op, .alu_a, .alu_b, .alu_swap,
        .alu_ready, .resp_valid, .resp_y0, .resp_y1
    );

endmodule

// ==== hw/ladder_sequencer.sv ====
`timescale 1ns/1ps
// Ladder sequencer
// control FSM of the engine: preloads the register file, walks the
// scalar from its top bit down, runs the step table on the field ALU
// for every bit and finishes with the closing conditional swap
module ladder_sequencer
    import ladder_pkg::*;
#(
    parameter int          WID = 16,
    parameter int unsigned A24 = 56144
)
(
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  logic [WID-1:0] in_scalar,
    input  logic [WID-1:0] in_base,
    output logic           in_ready,
    input  logic           out_ready,
    output logic           out_valid,
    output logic [WID-1:0] out_x,
    output logic [WID-1:0] out_z,
    output logic           alu_valid,
    output alu_op_e        alu_op,
    output logic [WID-1:0] alu_a,
    output logic [WID-1:0] alu_b,
    output logic           alu_swap,
    input  logic           alu_ready,
    input  logic           resp_valid,
    input  logic [WID-1:0] resp_y0,
    input  logic [WID-1:0] resp_y1,
    output reg_addr_e      ra_addr,
    output reg_addr_e      rb_addr,
    output logic           we,
    output reg_addr_e      wa,
    output logic [WID-1:0] wd,
    input  logic [WID-1:0] ra_data,
    input  logic [WID-1:0] rb_data
);

    localparam int CW = (WID > 1) ? $clog2(WID) : 1;

    typedef struct packed {
        alu_op_e        op;
        logic [WID-1:0] a;
        logic [WID-1:0] b;
        logic           swap;
    } alu_req_t;

    //////////////////////////////////////////////////
    // step table, a cswap writes y0 to dst and y1 to src_b
    localparam ladder_step_t STEP_TABLE [STEP_COUNT] = '{
        '{OP_CSWAP, R_X2,  R_X3, R_X2},
        '{OP_CSWAP, R_Z2,  R_Z3, R_Z2},
        '{OP_ADD,   R_X2,  R_Z2, R_A},   // A = x2+z2
        '{OP_MUL,   R_A,   R_A,  R_AA},
        '{OP_SUB,   R_X2,  R_Z2, R_B},
        '{OP_MUL,   R_B,   R_B,  R_BB},
        '{OP_SUB,   R_AA,  R_BB, R_E},
        '{OP_MUL,   R_AA,  R_BB, R_X2},  // new x2
        '{OP_MUL,   R_A24, R_E,  R_T0},
        '{OP_ADD,   R_AA,  R_T0, R_T0},
        '{OP_MUL,   R_E,   R_T0, R_Z2},  // new z2
        '{OP_ADD,   R_X3,  R_Z3, R_C},
        '{OP_SUB,   R_X3,  R_Z3, R_D},
        '{OP_MUL,   R_D,   R_A,  R_DA},
        '{OP_MUL,   R_C,   R_B,  R_CB},
        '{OP_ADD,   R_DA,  R_CB, R_X3},
        '{OP_MUL,   R_X3,  R_X3, R_X3},  // new x3
        '{OP_SUB,   R_DA,  R_CB, R_T0},
        '{OP_MUL,   R_T0,  R_T0, R_T0},
        '{OP_MUL,   R_X1,  R_T0, R_Z3},  // new z3
        '{OP_SUB,   R_T0,  R_T0, R_T0}   // wipe scratch T0
    };

    ladder_state_e         state;
    logic [WID-1:0]        scalar_q;
    logic [WID-1:0]        base_q;
    logic [CW-1:0]         bit_idx;
    logic [STEP_IDX_W-1:0] step_idx;
    logic [INIT_IDX_W-1:0] init_idx;
    logic                  swap_flag;   // previous scalar bit
    logic                  swap_sel;    // cswap control of this pass
    logic                  final_pass;
    logic [WID-1:0]        y1_q;
    alu_req_t              alu_q;
    ladder_step_t          cur;
    logic                  step_done;
    logic                  step_last;

    assign cur       = STEP_TABLE[step_idx];
    assign step_done = (state == S_WAIT && resp_valid && cur.op != OP_CSWAP)
                       || state == S_WB2;
    assign step_last = final_pass ? (step_idx == STEP_IDX_W'(1))
                                  : (step_idx == STEP_IDX_W'(STEP_COUNT-1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= S_IDLE;
            alu_valid  <= 1'b0;
            bit_idx    <= '0;
            step_idx   <= '0;
            init_idx   <= '0;
            swap_flag  <= 1'b0;
            swap_sel   <= 1'b0;
            final_pass <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    init_idx   <= '0;
                    swap_flag  <= 1'b0;
                    final_pass <= 1'b0;
                    if (in_valid)
                        state <= S_INIT;
                end
                S_INIT:
                begin
                    init_idx <= init_idx + 1'b1;
                    if (init_idx == INIT_IDX_W'(INIT_COUNT-1))
                    begin
                        bit_idx <= CW'(WID-1);
                        state   <= S_BIT;
                    end
                end
                S_BIT:
                begin
                    swap_sel  <= swap_flag ^ scalar_q[bit_idx];
                    swap_flag <= scalar_q[bit_idx];
                    step_idx  <= '0;
                    state     <= S_ISSUE;
                end
                S_ISSUE:
                begin
                    alu_valid <= 1'b1;
                    state     <= S_WAIT;
                end
                S_WAIT:
                begin
                    if (alu_valid && alu_ready)
                        alu_valid <= 1'b0;
                    if (resp_valid && cur.op == OP_CSWAP)
                        state <= S_WB2;
                end
                S_FINAL:
                begin
                    swap_sel   <= swap_flag;  // undo a pending swap
                    step_idx   <= '0;
                    final_pass <= 1'b1;
                    state      <= S_ISSUE;
                end
                S_DONE:
                begin
                    if (out_ready)
                        state <= S_IDLE;
                end
                default: state <= state;
            endcase

            // advance through the table
            if (step_done)
            begin
                if (!step_last)
                begin
                    step_idx <= step_idx + 1'b1;
                    state    <= S_ISSUE;
                end
                else if (final_pass)
                    state <= S_DONE;
                else if (bit_idx == '0)
                    state <= S_FINAL;
                else
                begin
                    bit_idx <= bit_idx - 1'b1;
                    state   <= S_BIT;
                end
            end
        end
    end

    // request and result payload
    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && in_valid)
        begin
            scalar_q <= in_scalar;
            base_q   <= in_base;
        end
        if (state == S_ISSUE)
            alu_q <= '{op: cur.op, a: ra_data, b: rb_data, swap: swap_sel};
        if (state == S_WAIT && resp_valid)
            y1_q <= resp_y1;
    end

    assign alu_op   = alu_q.op;
    assign alu_a    = alu_q.a;
    assign alu_b    = alu_q.b;
    assign alu_swap = alu_q.swap;

    assign in_ready  = (state == S_IDLE);
    assign out_valid = (state == S_DONE);
    assign ra_addr   = (state == S_DONE) ? R_X2 : cur.src_a;
    assign rb_addr   = (state == S_DONE) ? R_Z2 : cur.src_b;
    assign out_x     = ra_data;
    assign out_z     = rb_data;

    // register-file write, one slot per cycle during init
    always_comb
    begin
        we = 1'b0;
        wa = cur.dst;
        wd = resp_y0;
        case (state)
            S_INIT:
            begin
                we = 1'b1;
                case (init_idx)
                    3'd0:    begin wa = R_X1; wd = base_q;         end
                    3'd1:    begin wa = R_X2; wd = WID'(1);        end
                    3'd2:    begin wa = R_Z2; wd = '0;             end
                    3'd3:    begin wa = R_X3; wd = base_q;         end
                    3'd4:    begin wa = R_Z3; wd = WID'(1);        end
                    default: begin wa = R_A24; wd = WID'(A24);     end
                endcase
            end
            S_WAIT:  we = resp_valid;
            S_WB2:
            begin
                we = 1'b1;
                wa = cur.src_b;  // second half of the swap
                wd = y1_q;
            end
            default: we = 1'b0;
        endcase
    end

    a_step_range : assert property (@(posedge clk) disable iff (rst)
        step_idx < STEP_IDX_W'(STEP_COUNT));

endmodule

// ==== hw/field_alu.sv ====
`timescale 1ns/1ps
// Field ALU
// modular add and sub with a single correction, bit-serial
// MSB-first multiply reducing every step, and conditional swap
// one operation in flight and a single-cycle response pulse
module field_alu
    import ladder_pkg::*;
#(
    parameter int          WID     = 16,
    parameter int unsigned MODULUS = 65521
)
(
    input  logic           clk,
    input  logic           rst,
    input  logic           alu_valid,
    input  alu_op_e        alu_op,
    input  logic [WID-1:0] alu_a,
    input  logic [WID-1:0] alu_b,
    input  logic           alu_swap,
    output logic           alu_ready,
    output logic           resp_valid,
    output logic [WID-1:0] resp_y0,
    output logic [WID-1:0] resp_y1
);

    localparam int         CW    = (WID > 1) ? $clog2(WID) : 1;
    localparam logic [WID:0] MOD_W = (WID+1)'(MODULUS);

    typedef struct packed {
        alu_op_e        op;
        logic [WID-1:0] a;
        logic [WID-1:0] b;
        logic           swap;
    } alu_req_t;

    alu_req_t       req_q;      // operands held for the whole op
    logic           busy;       // accept through response
    logic           mul_run;
    logic [CW-1:0]  bit_idx;
    logic [WID-1:0] acc;
    logic           accept;
    logic [WID:0]   sum_w;
    logic [WID:0]   dif_w;
    logic [WID:0]   dbl_w;
    logic [WID:0]   dbl_r;
    logic [WID:0]   accum_w;
    logic [WID-1:0] add_res;
    logic [WID-1:0] sub_res;
    logic [WID-1:0] mul_next;

    assign alu_ready = !busy;
    assign accept    = alu_valid && alu_ready;

    //////////////////////////////////////////////////
    // datapath
    always_comb
    begin
        sum_w   = {1'b0, req_q.a} + {1'b0, req_q.b};
        add_res = (sum_w >= MOD_W) ? WID'(sum_w - MOD_W) : WID'(sum_w);
        dif_w   = {1'b0, req_q.a} - {1'b0, req_q.b};
        sub_res = dif_w[WID] ? WID'(dif_w + MOD_W) : WID'(dif_w); // borrow adds p back
        // double, reduce, then add a when the b bit is set
        dbl_w    = {acc, 1'b0};
        dbl_r    = (dbl_w >= MOD_W) ? dbl_w - MOD_W : dbl_w;
        accum_w  = dbl_r + (req_q.b[bit_idx] ? {1'b0, req_q.a} : '0);
        mul_next = (accum_w >= MOD_W) ? WID'(accum_w - MOD_W) : WID'(accum_w);
    end

    always_comb
    begin
        resp_y1 = req_q.b;
        case (req_q.op)
            OP_ADD:  resp_y0 = add_res;
            OP_SUB:  resp_y0 = sub_res;
            OP_MUL:  resp_y0 = acc;
            default:
            begin
                resp_y0 = req_q.swap ? req_q.b : req_q.a;
                resp_y1 = req_q.swap ? req_q.a : req_q.b;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // control
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy       <= 1'b0;
            mul_run    <= 1'b0;
            resp_valid <= 1'b0;
        end
        else
        begin
            resp_valid <= (accept && alu_op != OP_MUL) || (mul_run && bit_idx == '0);
            if (accept)
                busy <= 1'b1;
            else if (resp_valid)
                busy <= 1'b0;   // free again after the pulse
            if (accept && alu_op == OP_MUL)
                mul_run <= 1'b1;
            else if (mul_run && bit_idx == '0)
                mul_run <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_q   <= '{op: alu_op, a: alu_a, b: alu_b, swap: alu_swap};
            acc     <= '0;
            bit_idx <= CW'(WID-1);  // msb first
        end
        else if (mul_run)
        begin
            acc     <= mul_next;
            bit_idx <= bit_idx - 1'b1;
        end
    end

    // the requester holds off until the response is out
    a_no_overlap : assert property (@(posedge clk) disable iff (rst)
        !(resp_valid && alu_valid));

endmodule

// ==== hw/ladder_regfile.sv ====
`timescale 1ns/1ps
// Ladder register file
// sixteen working values of the engine, two asynchronous read ports
// and one synchronous write port, all steered by the sequencer
module ladder_regfile
    import ladder_pkg::*;
#(
    parameter int WID = 16
)
(
    input  logic           clk,
    input  logic           rst,
    input  reg_addr_e      ra_addr,
    input  reg_addr_e      rb_addr,
    input  logic           we,
    input  reg_addr_e      wa,
    input  logic [WID-1:0] wd,
    output logic [WID-1:0] ra_data,
    output logic [WID-1:0] rb_data
);

    localparam int SLOTS = 2 ** $bits(reg_addr_e);

    logic [WID-1:0] mem [SLOTS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < SLOTS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (we)
        begin
            mem[wa] <= wd;
        end
    end

    assign ra_data = mem[ra_addr]; // read through, no latency
    assign rb_data = mem[rb_addr];

    //////////////////////////////////////////////////
    // x1 and a24 only change inside the back-to-back init burst
    a_x1_init : assert property (@(posedge clk) disable iff (rst)
        (we && wa == R_X1) |=> (we && wa == R_X2));
    a_a24_init : assert property (@(posedge clk) disable iff (rst)
        (we && wa == R_A24) |-> $past(we && wa == R_Z3));

endmodule

// ==== hw/ladder_pkg.sv ====
// Montgomery ladder engine, shared definitions
// ALU opcodes, register-file slot names, sequencer states and the
// step-table entry format, plus the width helpers derived from them
package ladder_pkg;

    // field ALU operations
    typedef enum logic [1:0] {
        OP_ADD   = 2'd0,
        OP_SUB   = 2'd1,
        OP_MUL   = 2'd2,
        OP_CSWAP = 2'd3
    } alu_op_e;

    // working-value slots, ladder state first then scratch
    typedef enum logic [3:0] {
        R_X1,  R_X2,  R_Z2,  R_X3,
        R_Z3,  R_A24, R_A,   R_AA,
        R_B,   R_BB,  R_E,   R_C,
        R_D,   R_DA,  R_CB,  R_T0
    } reg_addr_e;

    typedef enum logic [2:0] {
        S_IDLE, // waiting for a request
        S_INIT, // preload x1 x2 z2 x3 z3 a24
        S_BIT,  // fetch next scalar bit, update swap
        S_ISSUE,
        S_WAIT,
        S_WB2,  // second result of a cswap
        S_FINAL,
        S_DONE
    } ladder_state_e;

    // one entry of the ladder step table, result goes to dst
    typedef struct packed {
        alu_op_e   op;
        reg_addr_e src_a;
        reg_addr_e src_b;
        reg_addr_e dst;
    } ladder_step_t;

    localparam int STEP_COUNT = 21;              // 2 cswap + 19 arithmetic
    localparam int STEP_IDX_W = $clog2(STEP_COUNT);
    localparam int INIT_COUNT = 6;               // slots written at start
    localparam int INIT_IDX_W = $clog2(INIT_COUNT);

endpackage
